// File: heapAllocator.sv
// Array heap allocator
// Hands out array numbers, preferring the most recently freed one, and
// tracks which arrays are currently live for the access checks

`timescale 1ns/1ps
`default_nettype none

module heapAllocator (
  input  logic               clock,
  input  logic               reset,
  input  logic               allocDo,
  input  logic               freeDo,
  input  logic               resetDo,
  input  heapPkg::arrayNum_t array,
  output heapPkg::arrayNum_t allocArray,
  output logic               allocAvailable,
  output logic               isAllocated,
  output logic               isFreed
);

  import heapPkg::*;

  arrayNum_t               freedStack [arrayCount];  // Freed arrays, most recent on top
  logic [arrayBits:0]      freedTop;                  // Entries on the stack
  logic [arrayBits:0]      freshCount;                // Arrays handed out from new
  logic [arrayCount-1:0]   allocFlags;                // Live arrays
  arrayNum_t               stackHead;

  // ----------------------------------------------------------------------
  // Next array to hand out
  // ----------------------------------------------------------------------
  assign stackHead = arrayNum_t'(freedTop - 1'b1);

  always_comb begin
    if (freedTop != '0) begin
      allocArray = freedStack[stackHead];             // Reuse before fresh
    end else begin
      allocArray = arrayNum_t'(freshCount);
    end
  end

  assign allocAvailable = (freedTop != '0) || (freshCount < arrayCount);

  // Status of the requested array
  assign isAllocated = {1'b0, array} < freshCount;
  assign isFreed     = !allocFlags[array];

  // ----------------------------------------------------------------------
  // Bookkeeping
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      freedTop   <= '0;
      freshCount <= '0;
      allocFlags <= '0;
    end else if (resetDo) begin
      freedTop   <= '0;                               // Empty both sources
      freshCount <= '0;
      allocFlags <= '0;
    end else if (allocDo) begin
      if (freedTop != '0) begin
        freedTop <= freedTop - 1'b1;
      end else begin
        freshCount <= freshCount + 1'b1;
      end
      allocFlags[allocArray] <= 1'b1;
    end else if (freeDo) begin
      freedTop          <= freedTop + 1'b1;
      allocFlags[array] <= 1'b0;                      // Flag of the freed array itself
    end
  end

  // A live array is freed at most once, so the stack never overflows
  always_ff @(posedge clock) begin
    if (freeDo && !resetDo && !allocDo) begin
      freedStack[arrayNum_t'(freedTop)] <= array;
    end
  end

endmodule

`default_nettype wire

// File: heapArrayStore.sv
// Array heap element storage
// Holds every slot of every array plus the current size of each array;
// reads are combinational, updates land on the clock edge

`timescale 1ns/1ps
`default_nettype none

module heapArrayStore (
  input  logic               clock,
  input  heapPkg::arrayNum_t array,
  input  heapPkg::index_t    index,
  input  logic               writeDo,
  input  heapPkg::data_t     writeData,
  input  logic               sizeDo,
  input  heapPkg::size_t     newSize,
  output heapPkg::size_t     size,
  output heapPkg::data_t     element
);

  import heapPkg::*;

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  data_t memory [arrayCount][arrayLength];        // One fixed block per array
  size_t sizes  [arrayCount];                     // Elements in use per array

  // ----------------------------------------------------------------------
  // Read side
  // ----------------------------------------------------------------------
  // The controller steers the index for push and pop, so the element
  // seen here is already the slot that the operation needs
  assign size    = sizes[array];
  assign element = memory[array][index];

  // ----------------------------------------------------------------------
  // Update side
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (writeDo) begin
      memory[array][index] <= writeData;          // Write and push
    end
  end

  // Alloc zeroes the size here, so a stale size never leaks to a client
  always_ff @(posedge clock) begin
    if (sizeDo) begin
      sizes[array] <= newSize;                    // Grow, shrink or clear
    end
  end

endmodule

`default_nettype wire

// File: heapCheck_sva.sv
// Array heap handshake checker
// Reset values, response stability and the one-in-flight rule,
// bound into the heap top level

`timescale 1ns/1ps
`default_nettype none

module heapCheck (
  input logic                clock,
  input logic                reset,
  input logic                reqValid,
  input logic                reqReady,
  input logic                respValid,
  input logic                respReady,
  input heapPkg::data_t      respData,
  input heapPkg::heapError_t respError
);

  int errorCount = 0;                             // Failed assertions so far

  // ----------------------------------------------------------------------
  // Reset and handshake properties
  // ----------------------------------------------------------------------
  idleInReset: assert property (@(posedge clock) !reset |-> !respValid && reqReady)
    else begin
      $error("Response channel not idle during reset");
      errorCount++;
    end

  holdWhileStalled: assert property (@(posedge clock) disable iff (!reset)
      respValid && !respReady |=> respValid && $stable(respData) && $stable(respError))
    else begin
      $error("Response changed while stalled");
      errorCount++;
    end

  responseFollows: assert property (@(posedge clock) disable iff (!reset)
      reqValid && reqReady |=> respValid)
    else begin
      $error("No response on the edge after acceptance");
      errorCount++;
    end

  readyLowWhileStalled: assert property (@(posedge clock) disable iff (!reset)
      respValid && !respReady |-> !reqReady)
    else begin
      $error("Request accepted while a response stalls");
      errorCount++;
    end

endmodule

bind heapTop heapCheck i_check (
  .clock, .reset, .reqValid, .reqReady, .respValid, .respReady, .respData, .respError
);

`default_nettype wire

// File: heapController.sv
// Array heap controller
// Accepts one request at a time, runs the allocation and bounds checks,
// drives the allocator and store updates and registers the response

`timescale 1ns/1ps
`default_nettype none

module heapController (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 reqValid,
  output logic                 reqReady,
  input  heapPkg::heapAction_t reqAction,
  input  heapPkg::arrayNum_t   reqArray,
  input  heapPkg::index_t      reqIndex,
  input  heapPkg::data_t       reqData,
  output logic                 respValid,
  input  logic                 respReady,
  output heapPkg::data_t       respData,
  output heapPkg::heapError_t  respError,
  output logic                 allocDo,
  output logic                 freeDo,
  output logic                 resetDo,
  input  heapPkg::arrayNum_t   allocArray,
  input  logic                 allocAvailable,
  input  logic                 isAllocated,
  input  logic                 isFreed,
  output heapPkg::arrayNum_t   storeArray,
  output heapPkg::index_t      storeIndex,
  output logic                 writeDo,
  output heapPkg::data_t       writeData,
  output logic                 sizeDo,
  output heapPkg::size_t       newSize,
  input  heapPkg::size_t       size,
  input  heapPkg::data_t       element
);

  import heapPkg::*;

  logic       accept;                             // Request transfers this edge
  logic       update;                             // Accepted without error
  heapError_t accessError;                        // Outcome of the writeable check
  heapError_t nextError;
  data_t      nextData;
  logic       wantAlloc;
  logic       wantFree;
  logic       wantReset;
  logic       wantWrite;
  logic       wantSize;

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------
  assign reqReady = !respValid || respReady;      // One operation in flight
  assign accept   = reqValid && reqReady;

  // Not allocated takes priority over freed
  assign accessError = !isAllocated ? ErrNotAllocated :
                       isFreed      ? ErrFreed        : ErrNone;

  // ----------------------------------------------------------------------
  // Decode and checks
  // ----------------------------------------------------------------------
  always_comb begin
    nextError  = ErrNone;
    nextData   = '0;                              // Errors and Free give zero
    wantAlloc  = 1'b0;
    wantFree   = 1'b0;
    wantReset  = 1'b0;
    wantWrite  = 1'b0;
    wantSize   = 1'b0;
    storeArray = reqArray;
    storeIndex = reqIndex;
    writeData  = reqData;
    newSize    = size;

    case (reqAction)
      ActReset: begin
        wantReset = 1'b1;
      end
      ActAlloc: begin
        storeArray = allocArray;                  // Zero the size of the new array
        if (!allocAvailable) begin
          nextError = ErrOutOfMemory;
        end else begin
          wantAlloc = 1'b1;
          wantSize  = 1'b1;
          newSize   = '0;
          nextData  = data_t'(allocArray);
        end
      end
      ActFree: begin
        nextError = accessError;
        wantFree  = 1'b1;
      end
      ActWrite: begin
        nextError = accessError;
        wantWrite = 1'b1;
        nextData  = reqData;
        if (size_t'(reqIndex) >= size) begin
          wantSize = 1'b1;                        // Grow to cover the index
          newSize  = size_t'(reqIndex) + size_t'(1);
        end
      end
      ActRead: begin
        if (accessError != ErrNone) begin
          nextError = accessError;
        end else if (size_t'(reqIndex) >= size) begin
          nextError = ErrOutOfBounds;
        end else begin
          nextData = element;
        end
      end
      ActSize: begin
        nextError = accessError;
        nextData  = data_t'(size);
      end
      ActPush: begin
        storeIndex = index_t'(size);              // First unused slot
        if (accessError != ErrNone) begin
          nextError = accessError;
        end else if (size == size_t'(arrayLength)) begin
          nextError = ErrFull;
        end else begin
          wantWrite = 1'b1;
          wantSize  = 1'b1;
          newSize   = size + size_t'(1);
          nextData  = reqData;
        end
      end
      ActPop: begin
        storeIndex = index_t'(size - size_t'(1)); // Last used slot
        if (accessError != ErrNone) begin
          nextError = accessError;
        end else if (size == '0) begin
          nextError = ErrEmpty;
        end else begin
          wantSize = 1'b1;
          newSize  = size - size_t'(1);
          nextData = element;
        end
      end
      ActResize: begin
        if (accessError != ErrNone) begin
          nextError = accessError;
        end else if (reqData > data_t'(arrayLength)) begin
          nextError = ErrTooLarge;
        end else begin
          wantSize = 1'b1;
          newSize  = size_t'(reqData);
          nextData = reqData;
        end
      end
      default: begin
        nextData = '0;
      end
    endcase

    // Any error leaves the result at zero
    if (nextError != ErrNone) begin
      nextData = '0;
    end
  end

  // Strobes fire only on the accepting edge of an error-free request
  assign update  = accept && (nextError == ErrNone);
  assign allocDo = update && wantAlloc;
  assign freeDo  = update && wantFree;
  assign resetDo = update && wantReset;
  assign writeDo = update && wantWrite;
  assign sizeDo  = update && wantSize;

  // ----------------------------------------------------------------------
  // Response register
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      respValid <= 1'b0;
    end else if (accept) begin
      respValid <= 1'b1;                          // Next cycle after acceptance
    end else if (respReady) begin
      respValid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      respData  <= nextData;                      // Held while stalled
      respError <= nextError;
    end
  end

endmodule

`default_nettype wire

// File: heapPkg.sv
// Array heap shared definitions
// Widths, counts, request actions, error codes and the derived types
// used by the controller, the allocator and the array store

`default_nettype none

package heapPkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int arrayBits   = 2;                 // Bits in an array number
  localparam int indexBits   = 3;                 // Bits in an element index
  localparam int dataBits    = 12;                // Bits in an element
  localparam int arrayCount  = 2 ** arrayBits;    // Arrays held by the heap
  localparam int arrayLength = 2 ** indexBits;    // Slots in each array

  // ----------------------------------------------------------------------
  // Derived types
  // ----------------------------------------------------------------------
  typedef logic [arrayBits-1:0] arrayNum_t;       // Array number
  typedef logic [indexBits-1:0] index_t;          // Element index
  typedef logic [indexBits:0]   size_t;           // Size, holds the full length
  typedef logic [dataBits-1:0]  data_t;           // Element value

  // Operations accepted on the request channel
  typedef enum logic [3:0] {
    ActReset,                                     // Forget every array
    ActAlloc,                                     // Hand out an empty array
    ActFree,                                      // Return an array for reuse
    ActWrite,                                     // Store an element
    ActRead,                                      // Fetch an element
    ActSize,                                      // Report the size
    ActPush,                                      // Append an element
    ActPop,                                       // Remove the last element
    ActResize                                     // Set the size directly
  } heapAction_t;

  // Outcome reported with every response
  typedef enum logic [2:0] {
    ErrNone,
    ErrNotAllocated,                              // Array never handed out
    ErrFreed,                                     // Array handed out, then freed
    ErrOutOfBounds,                               // Index at or above the size
    ErrFull,                                      // Push onto a full array
    ErrEmpty,                                     // Pop from an empty array
    ErrOutOfMemory,                               // No array left to hand out
    ErrTooLarge                                   // Resize beyond the length
  } heapError_t;

endpackage

`default_nettype wire

// File: heapTb.sv
// Array heap testbench
// Drives allocation, access, push/pop and reset sequences with random
// stalls and checks every response against a reference model

`timescale 1ns/1ps
`default_nettype none

module heapTb;

  import heapPkg::*;

  logic        clock;
  logic        reset;
  logic        reqValid;
  logic        reqReady;
  heapAction_t reqAction;
  arrayNum_t   reqArray;
  index_t      reqIndex;
  data_t       reqData;
  logic        respValid;
  logic        respReady;
  data_t       respData;
  heapError_t  respError;

  logic [31:0] lfsrState = 32'ha328;
  data_t       expDataQueue [$];                  // Expected results, oldest first
  heapError_t  expErrorQueue [$];
  logic        headValid = 1'b0;
  data_t       headData;
  heapError_t  headError;

  // Reference model state
  int          freshCount;
  arrayNum_t   freedStack [$];
  logic        live [arrayCount];
  int          modelSize [arrayCount];
  data_t       modelMem [arrayCount][arrayLength];

  heapTop i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // ----------------------------------------------------------------------
  // Random source
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    int          bitNum;
    value = '0;
    for (bitNum = 0; bitNum < count; bitNum++) begin
      lfsrState = lfsrStep(lfsrState);
      value     = {value[30:0], lfsrState[0]};  // One step per bit
    end
    return value;
  endfunction

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic void clearModel();
    int slot;
    freshCount = 0;
    freedStack.delete();
    for (slot = 0; slot < arrayCount; slot++) begin
      live[slot]      = 1'b0;
      modelSize[slot] = 0;
    end
  endfunction

  function automatic heapError_t accessCheck(input arrayNum_t array);
    if (array >= freshCount) return ErrNotAllocated;
    if (!live[array]) return ErrFreed;
    return ErrNone;
  endfunction

  task automatic modelRequest(input heapAction_t action, input arrayNum_t array,
                              input index_t index, input data_t data,
                              output data_t result, output heapError_t error);
    int slot;
    error  = accessCheck(array);
    result = '0;                                  // Errors, Free and Reset give zero
    case (action)
      ActReset: begin
        error = ErrNone;
        clearModel();
      end
      ActAlloc: begin
        error = ErrNone;
        if (freedStack.size() != 0) begin
          slot = freedStack.pop_back();           // Most recently freed first
        end else if (freshCount < arrayCount) begin
          slot = freshCount;
          freshCount++;
        end else begin
          error = ErrOutOfMemory;
        end
        if (error == ErrNone) begin
          live[slot]      = 1'b1;
          modelSize[slot] = 0;
          result          = data_t'(slot);
        end
      end
      ActFree: if (error == ErrNone) begin
        live[array] = 1'b0;
        freedStack.push_back(array);
      end
      ActWrite: if (error == ErrNone) begin
        modelMem[array][index] = data;
        if (index + 1 > modelSize[array]) modelSize[array] = index + 1;
        result = data;
      end
      ActRead: begin
        if (error == ErrNone && index >= modelSize[array]) error = ErrOutOfBounds;
        if (error == ErrNone) result = modelMem[array][index];
      end
      ActSize: if (error == ErrNone) result = data_t'(modelSize[array]);
      ActPush: begin
        if (error == ErrNone && modelSize[array] == arrayLength) error = ErrFull;
        if (error == ErrNone) begin
          modelMem[array][modelSize[array]] = data;
          modelSize[array]++;
          result = data;
        end
      end
      ActPop: begin
        if (error == ErrNone && modelSize[array] == 0) error = ErrEmpty;
        if (error == ErrNone) begin
          modelSize[array]--;
          result = modelMem[array][modelSize[array]];
        end
      end
      ActResize: begin
        if (error == ErrNone && data > arrayLength) error = ErrTooLarge;
        if (error == ErrNone) begin
          modelSize[array] = data;
          result           = data;
        end
      end
      default: error = ErrNone;
    endcase
  endtask

  // Queue upkeep; a transfer retires the head before a new request joins
  always @(posedge clock) begin
    data_t      expData;
    heapError_t expError;
    if (reset) begin
      if (respValid && respReady && expDataQueue.size() != 0) begin
        void'(expDataQueue.pop_front());
        void'(expErrorQueue.pop_front());
      end
      if (reqValid && reqReady) begin
        modelRequest(reqAction, reqArray, reqIndex, reqData, expData, expError);
        expDataQueue.push_back(expData);
        expErrorQueue.push_back(expError);
      end
    end
    headValid <= expDataQueue.size() != 0;
    headData  <= (expDataQueue.size() != 0) ? expDataQueue[0] : '0;
    headError <= (expErrorQueue.size() != 0) ? expErrorQueue[0] : ErrNone;
  end

  always @(posedge clock) begin
    respReady <= takeBits(2) != 0;                // Ready three times in four
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  pendingCheck: assert property (@(posedge clock) disable iff (!reset)
      respValid && respReady |-> headValid)
    else begin
      $display("A response was transferred with no request pending");
      $display("Errors found");
      $fatal(1, "Unexpected response");
    end

  responseCheck: assert property (@(posedge clock) disable iff (!reset)
      respValid && respReady && headValid |->
        respData === headData && respError === headError)
    else begin
      $display("** Error at %0t: response data %h error %0d, expected data %h error %0d",
               $time, $sampled(respData), $sampled(respError), $sampled(headData),
               $sampled(headError));
      $display("Errors found");
      $fatal(1, "Response mismatch");
    end

  always @(posedge clock) begin
    if (i_dut.i_check.errorCount != 0) begin
      $display("Errors found");
      $fatal(1, "A handshake assertion failed");
    end
  end

  task automatic sendRequest(input heapAction_t action, input arrayNum_t array,
                             input index_t index, input data_t data);
    int cycles;
    reqValid  <= 1'b1;
    reqAction <= action;
    reqArray  <= array;
    reqIndex  <= index;
    reqData   <= data;
    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
      if (cycles > 100) begin
        $display("A request was not accepted within 100 cycles");
        $display("Errors found");
        $fatal(1, "Timeout waiting for reqReady");
      end
    end while (!reqReady);
    reqValid <= 1'b0;                             // Next call may raise it again
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    logic [arrayLength-1:0] written;
    index_t                 index;
    int                     slot;
    int                     cycles;
    reset     = 1'b0;
    reqValid  = 1'b0;
    reqAction = ActReset;
    reqArray  = '0;
    reqIndex  = '0;
    reqData   = '0;
    respReady = 1'b0;
    clearModel();
    repeat (10) @(posedge clock);
    reset <= 1'b1;

    sendRequest(ActAlloc, 0, 0, 0);
    sendRequest(ActAlloc, 0, 0, 0);
    sendRequest(ActWrite, 3, 0, 12'h5a5);         // Not handed out yet
    repeat (3) sendRequest(ActAlloc, 0, 0, 0);    // Arrays 2 and 3, then out of memory
    sendRequest(ActFree, 2, 0, 0);
    sendRequest(ActRead, 2, 0, 0);                // Freed
    sendRequest(ActFree, 2, 0, 0);
    sendRequest(ActAlloc, 0, 0, 0);               // LIFO reuse of array 2

    written = '0;
    repeat (6) begin
      index          = index_t'(takeBits(indexBits));
      written[index] = 1'b1;
      sendRequest(ActWrite, 0, index, data_t'(takeBits(dataBits)));
    end
    sendRequest(ActSize, 0, 0, 0);
    for (slot = 0; slot < arrayLength; slot++) begin
      if (written[slot]) sendRequest(ActRead, 0, index_t'(slot), 0);
    end
    sendRequest(ActRead, 1, 0, 0);                // Empty array, out of bounds

    repeat (arrayLength + 1) sendRequest(ActPush, 1, 0, data_t'(takeBits(dataBits)));
    repeat (arrayLength + 1) sendRequest(ActPop, 1, 0, 0);
    sendRequest(ActResize, 1, 0, data_t'(arrayLength + 1));
    sendRequest(ActResize, 1, 0, 3);
    sendRequest(ActSize, 1, 0, 0);
    sendRequest(ActPop, 1, 0, 0);

    sendRequest(ActReset, 0, 0, 0);
    sendRequest(ActRead, 1, 0, 0);
    sendRequest(ActAlloc, 0, 0, 0);               // Back to array 0

    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
      if (cycles > 100) begin
        $display("Responses still pending after 100 cycles");
        $display("Errors found");
        $fatal(1, "Timeout waiting for the last response");
      end
    end while (headValid);

    if (i_dut.i_check.errorCount != 0) begin
      $display("Errors found");
      $fatal(1, "A handshake assertion failed");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: heapTop.sv
// Array heap top level
// Connects the request and response channels to the controller, which
// drives the allocator and the element store

`timescale 1ns/1ps
`default_nettype none

module heapTop (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 reqValid,
  output logic                 reqReady,
  input  heapPkg::heapAction_t reqAction,
  input  heapPkg::arrayNum_t   reqArray,
  input  heapPkg::index_t      reqIndex,
  input  heapPkg::data_t       reqData,
  output logic                 respValid,
  input  logic                 respReady,
  output heapPkg::data_t       respData,
  output heapPkg::heapError_t  respError
);

  import heapPkg::*;

  // Controller to allocator
  logic      allocDo;
  logic      freeDo;
  logic      resetDo;
  arrayNum_t allocArray;
  logic      allocAvailable;
  logic      isAllocated;
  logic      isFreed;

  // Controller to store
  arrayNum_t storeArray;
  index_t    storeIndex;
  logic      writeDo;
  data_t     writeData;
  logic      sizeDo;
  size_t     newSize;
  size_t     size;
  data_t     element;

  heapController i_controller (
    .clock, .reset,
    .reqValid, .reqReady, .reqAction, .reqArray, .reqIndex, .reqData,
    .respValid, .respReady, .respData, .respError,
    .allocDo, .freeDo, .resetDo,
    .allocArray, .allocAvailable, .isAllocated, .isFreed,
    .storeArray, .storeIndex, .writeDo, .writeData,
    .sizeDo, .newSize, .size, .element
  );

  heapAllocator i_allocator (
    .clock, .reset,
    .allocDo, .freeDo, .resetDo,
    .array (reqArray),                            // Checks follow the request
    .allocArray, .allocAvailable, .isAllocated, .isFreed
  );

  heapArrayStore i_store (
    .clock,
    .array (storeArray),
    .index (storeIndex),
    .writeDo, .writeData, .sizeDo, .newSize,
    .size, .element
  );

endmodule

`default_nettype wire

// File: project.f
heapPkg.sv
heapAllocator.sv
heapArrayStore.sv
heapController.sv
heapTop.sv
heapCheck_sva.sv
heapTb.sv
